// File: source/mem_pkg.sv
// ****************************************
// Scratchpad memory shared definitions
// Column geometry, word types and agent states
// ****************************************

package mem_pkg;

  // Column geometry of one RAM word
  localparam int COL_WIDTH = 8;                   // Bits per byte column
  localparam int NB_COL    = 4;                   // Byte columns per word
  localparam int WORD_W    = NB_COL * COL_WIDTH;  // Full word width

  // Data word as seen by clients and RAM
  typedef logic [WORD_W-1:0] word_t;

  // One enable bit per byte column
  typedef logic [NB_COL-1:0] be_t;

  // Port agent sequencing
  typedef enum logic [1:0] {
    IDLE   = 2'd0,  // Waiting for req
    ACCESS = 2'd1,  // RAM enable cycle
    WAIT   = 2'd2,  // Output register load cycles
    ACK    = 2'd3   // Capture word then hold ack
  } agent_state_t;

endpackage : mem_pkg

// File: source/dpram_byte_write.sv
// ****************************************
// True dual-port byte-write RAM
// Write-first per port, port A wins on collision
// Optional output register on both read ports
// ****************************************
`timescale 1ns/100ps

module dpram_byte_write #(
  parameter int  RAM_DEPTH = 256,                // Number of words
  parameter int  OUT_REG   = 1,                  // 1 adds the output register
  localparam int ADDR_W    = $clog2(RAM_DEPTH)   // Address bits
) (
  input  logic                clka,    // Shared clock for both ports
  input  logic                rsta,    // Clears output registers only
  input  logic                ena,     // Port A access enable
  input  logic                enb,     // Port B access enable
  input  mem_pkg::be_t        wea,     // Port A byte write mask
  input  mem_pkg::be_t        web,     // Port B byte write mask
  input  logic [ADDR_W-1:0]   addra,   // Port A word address
  input  logic [ADDR_W-1:0]   addrb,   // Port B word address
  input  mem_pkg::word_t      dina,    // Port A write data
  input  mem_pkg::word_t      dinb,    // Port B write data
  input  logic                regcea,  // Port A output register load
  input  logic                regceb,  // Port B output register load
  output mem_pkg::word_t      douta,   // Port A read word
  output mem_pkg::word_t      doutb    // Port B read word
);
  import mem_pkg::*;

  // Storage array, starts cleared and is never reset
  word_t mem [RAM_DEPTH] = '{default: '0};

  // Port side signals gathered by index, 0 is A and 1 is B
  logic              en_v    [2];
  be_t               we_v    [2];
  logic [ADDR_W-1:0] addr_v  [2];
  word_t             din_v   [2];
  logic              regce_v [2];
  word_t             out_v   [2];

  assign en_v[0]    = ena;
  assign en_v[1]    = enb;
  assign we_v[0]    = wea;
  assign we_v[1]    = web;
  assign addr_v[0]  = addra;
  assign addr_v[1]  = addrb;
  assign din_v[0]   = dina;
  assign din_v[1]   = dinb;
  assign regce_v[0] = regcea;
  assign regce_v[1] = regceb;

  // New bytes where the mask is set, old bytes elsewhere
  function automatic word_t merge_cols(word_t old_w, word_t new_w, be_t mask);
    word_t res;
    res = old_w;
    for (int c = 0; c < NB_COL; c++) begin
      if (mask[c]) begin
        res[c*COL_WIDTH +: COL_WIDTH] = new_w[c*COL_WIDTH +: COL_WIDTH];
      end
    end
    return res;
  endfunction

  // Column writes, port B first so port A lands last on shared bytes
  always_ff @(posedge clka) begin
    for (int c = 0; c < NB_COL; c++) begin
      if (enb && web[c]) begin
        mem[addrb][c*COL_WIDTH +: COL_WIDTH] <= dinb[c*COL_WIDTH +: COL_WIDTH];
      end
      if (ena && wea[c]) begin  // A overrides B on the same byte
        mem[addra][c*COL_WIDTH +: COL_WIDTH] <= dina[c*COL_WIDTH +: COL_WIDTH];
      end
    end
  end

  // Read path per port
  for (genvar p = 0; p < 2; p++) begin : g_port
    word_t raw_q;  // Write-first read word, held while disabled

    always_ff @(posedge clka) begin
      if (en_v[p]) begin
        raw_q <= merge_cols(mem[addr_v[p]], din_v[p], we_v[p]);  // Own write shows through
      end
    end

    if (OUT_REG != 0) begin : g_oreg
      word_t out_q;  // Output register, two cycle latency

      always_ff @(posedge clka) begin
        if (rsta) begin
          out_q <= '0;
        end else if (regce_v[p]) begin
          out_q <= raw_q;  // Loads only when the agent asks
        end
      end

      assign out_v[p] = out_q;
    end else begin : g_direct
      assign out_v[p] = raw_q;  // One cycle latency
    end
  end

  assign douta = out_v[0];
  assign doutb = out_v[1];

endmodule : dpram_byte_write

// File: source/port_agent.sv
// ****************************************
// Four-phase client port agent
// Turns req/ack into timed RAM port controls
// ****************************************
`timescale 1ns/100ps

module port_agent #(
  parameter int  RAM_DEPTH = 256,                // Number of RAM words
  parameter int  OUT_REG   = 1,                  // RAM output register stages
  localparam int ADDR_W    = $clog2(RAM_DEPTH)   // Address bits
) (
  input  logic                clka,       // System clock
  input  logic                rsta,       // Sync reset, active high
  input  logic                req,        // Client request level
  input  logic                we,         // 1 for write, 0 for read
  input  mem_pkg::be_t        be,         // Client byte enables
  input  logic [ADDR_W-1:0]   addr,       // Client word address
  input  mem_pkg::word_t      wdata,      // Client write data
  output logic                ack,        // Completion level
  output mem_pkg::word_t      rdata,      // Word returned by the RAM
  output logic                ram_en,     // RAM port enable
  output mem_pkg::be_t        ram_we,     // RAM byte write mask
  output logic [ADDR_W-1:0]   ram_addr,   // RAM port address
  output mem_pkg::word_t      ram_din,    // RAM write data
  output logic                ram_regce,  // RAM output register load
  input  mem_pkg::word_t      ram_dout    // RAM read word
);
  import mem_pkg::*;

  // Wait counter sized for the output register depth
  localparam int                CNT_W     = (OUT_REG > 1) ? $clog2(OUT_REG) : 1;
  localparam logic [CNT_W-1:0]  WAIT_LAST = CNT_W'(OUT_REG - 1);  // Final WAIT count

  agent_state_t      state;     // Handshake and access sequencing
  logic [CNT_W-1:0]  wait_cnt;  // Cycles spent in WAIT
  logic              ack_q;     // Registered ack level
  word_t             rdata_q;   // Captured RAM word
  logic              accept;    // New request taken this cycle

  // Command copy, stable for the whole access
  be_t               cmd_mask;  // Byte mask, zero on reads
  logic [ADDR_W-1:0] cmd_addr;
  word_t             cmd_din;

  assign accept = (state == IDLE) && req;  // Only from IDLE, so ack must be low

  // Control path
  always_ff @(posedge clka) begin
    if (rsta) begin
      state    <= IDLE;
      wait_cnt <= '0;
      ack_q    <= 1'b0;
      rdata_q  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            state <= ACCESS;  // Command registered on this edge
          end
        end
        ACCESS: begin
          wait_cnt <= '0;
          state    <= (OUT_REG > 0) ? WAIT : ACK;  // Skip WAIT without output register
        end
        WAIT: begin
          if (wait_cnt == WAIT_LAST) begin
            state <= ACK;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        ACK: begin
          if (!ack_q) begin
            rdata_q <= ram_dout;  // Word settled, take it and raise ack
            ack_q   <= 1'b1;
          end else if (!req) begin
            ack_q <= 1'b0;  // Client released, close the handshake
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Command register, loaded only at acceptance
  always_ff @(posedge clka) begin
    if (accept) begin
      cmd_mask <= we ? be : '0;  // Reads never write
      cmd_addr <= addr;
      cmd_din  <= wdata;
    end
  end

  // RAM port drive
  assign ram_en    = (state == ACCESS);                   // Single access cycle
  assign ram_we    = (state == ACCESS) ? cmd_mask : '0;   // Mask only with enable
  assign ram_addr  = cmd_addr;
  assign ram_din   = cmd_din;
  assign ram_regce = (state == WAIT);                     // Load output register

  // Client side
  assign ack   = ack_q;
  assign rdata = rdata_q;  // Held until next capture

endmodule : port_agent

// File: source/mem_subsys.sv
// ****************************************
// Two-client scratchpad memory subsystem
// Two port agents over one dual-port RAM
// ****************************************
`timescale 1ns/100ps

module mem_subsys #(
  parameter int  RAM_DEPTH = 256,                // Scratchpad words
  parameter int  OUT_REG   = 1,                  // 1 for registered RAM output
  localparam int ADDR_W    = $clog2(RAM_DEPTH)   // Address bits
) (
  input  logic                clka,     // System clock
  input  logic                rsta,     // Sync reset, active high
  // Client A
  input  logic                a_req,
  input  logic                a_we,
  input  mem_pkg::be_t        a_be,
  input  logic [ADDR_W-1:0]   a_addr,
  input  mem_pkg::word_t      a_wdata,
  output logic                a_ack,
  output mem_pkg::word_t      a_rdata,
  // Client B
  input  logic                b_req,
  input  logic                b_we,
  input  mem_pkg::be_t        b_be,
  input  logic [ADDR_W-1:0]   b_addr,
  input  mem_pkg::word_t      b_wdata,
  output logic                b_ack,
  output mem_pkg::word_t      b_rdata
);
  import mem_pkg::*;

  // Agent A to RAM port A
  logic              a_ram_en;
  be_t               a_ram_we;
  logic [ADDR_W-1:0] a_ram_addr;
  word_t             a_ram_din;
  logic              a_ram_regce;
  word_t             a_ram_dout;

  // Agent B to RAM port B
  logic              b_ram_en;
  be_t               b_ram_we;
  logic [ADDR_W-1:0] b_ram_addr;
  word_t             b_ram_din;
  logic              b_ram_regce;
  word_t             b_ram_dout;

  port_agent #(
    .RAM_DEPTH (RAM_DEPTH),
    .OUT_REG   (OUT_REG)
  ) u_agent_a (
    .clka      (clka),
    .rsta      (rsta),
    .req       (a_req),
    .we        (a_we),
    .be        (a_be),
    .addr      (a_addr),
    .wdata     (a_wdata),
    .ack       (a_ack),
    .rdata     (a_rdata),
    .ram_en    (a_ram_en),
    .ram_we    (a_ram_we),
    .ram_addr  (a_ram_addr),
    .ram_din   (a_ram_din),
    .ram_regce (a_ram_regce),
    .ram_dout  (a_ram_dout)
  );

  port_agent #(
    .RAM_DEPTH (RAM_DEPTH),
    .OUT_REG   (OUT_REG)
  ) u_agent_b (
    .clka      (clka),
    .rsta      (rsta),
    .req       (b_req),
    .we        (b_we),
    .be        (b_be),
    .addr      (b_addr),
    .wdata     (b_wdata),
    .ack       (b_ack),
    .rdata     (b_rdata),
    .ram_en    (b_ram_en),
    .ram_we    (b_ram_we),
    .ram_addr  (b_ram_addr),
    .ram_din   (b_ram_din),
    .ram_regce (b_ram_regce),
    .ram_dout  (b_ram_dout)
  );

  // Port A of the RAM has priority on same-address byte collisions
  dpram_byte_write #(
    .RAM_DEPTH (RAM_DEPTH),
    .OUT_REG   (OUT_REG)
  ) u_ram (
    .clka      (clka),
    .rsta      (rsta),
    .ena       (a_ram_en),
    .enb       (b_ram_en),
    .wea       (a_ram_we),
    .web       (b_ram_we),
    .addra     (a_ram_addr),
    .addrb     (b_ram_addr),
    .dina      (a_ram_din),
    .dinb      (b_ram_din),
    .regcea    (a_ram_regce),
    .regceb    (b_ram_regce),
    .douta     (a_ram_dout),
    .doutb     (b_ram_dout)
  );

endmodule : mem_subsys

// File: dv/tb_mem_subsys.sv
// ****************************************
// Testbench for the two-client scratchpad
// Shadow model, handshake assertions, watchdog
// ****************************************
`timescale 1ns/100ps

module tb_mem_subsys;
  import mem_pkg::*;

  localparam int RAM_DEPTH    = 256;                // DUT default depth
  localparam int OUT_REG      = 1;                  // DUT default output mode
  localparam int ADDR_W       = $clog2(RAM_DEPTH);
  localparam int CLK_PERIOD   = 40;                 // ns
  localparam int LAT          = 2 + OUT_REG;        // Edges from req sample to ack rise
  localparam int ACK_WAIT_MAX = LAT + 8;            // Per-phase handshake limit in cycles

  // Transactions per test
  localparam int N_HS       = 4;
  localparam int N_MERGE    = 8;
  localparam int N_PAIRS    = 4;                    // Four transactions each
  localparam int N_RAND_RD  = 8;
  localparam int N_COLL     = 4;                    // Five transactions each
  localparam int N_MIX      = 200;
  localparam int TOTAL_TXN  = N_HS + N_MERGE + 4 * N_PAIRS + N_RAND_RD + 5 * N_COLL + N_MIX;
  localparam int MARGIN_CYC = 200;
  localparam int WATCHDOG_NS = (TOTAL_TXN * (OUT_REG + 6) + MARGIN_CYC) * CLK_PERIOD;

  typedef logic [ADDR_W-1:0] addr_t;

  logic  clka;
  logic  rsta;
  logic  req_q   [2];  // Index 0 is client A and 1 is client B
  logic  we_q    [2];
  be_t   be_q    [2];
  addr_t addr_q  [2];
  word_t wdata_q [2];
  logic  ack_w   [2];
  word_t rdata_w [2];
  logic  a_ack;
  logic  b_ack;
  word_t a_rdata;
  word_t b_rdata;

  // Reference model state
  word_t shadow     [RAM_DEPTH] = '{default: '0};  // RAM contents starting at zero
  be_t   post_mask  [2];                           // Mask seen by the RAM and zero on reads
  addr_t post_addr  [2];
  word_t post_wdata [2];
  int    post_seq   [2] = '{0, 0};                 // Bumped on each RAM access edge
  int    seen_seq   [2] = '{0, 0};                 // Last access folded into the model
  word_t exp_rdata  [2];                           // Word expected with the next ack

  int fail_cnt = 0;
  int txn_cnt  = 0;
  int test_cnt = 0;

  assign ack_w[0]   = a_ack;
  assign ack_w[1]   = b_ack;
  assign rdata_w[0] = a_rdata;
  assign rdata_w[1] = b_rdata;

  mem_subsys #(
    .RAM_DEPTH (RAM_DEPTH),
    .OUT_REG   (OUT_REG)
  ) uut (
    .clka    (clka),
    .rsta    (rsta),
    .a_req   (req_q[0]),
    .a_we    (we_q[0]),
    .a_be    (be_q[0]),
    .a_addr  (addr_q[0]),
    .a_wdata (wdata_q[0]),
    .a_ack   (a_ack),
    .a_rdata (a_rdata),
    .b_req   (req_q[1]),
    .b_we    (we_q[1]),
    .b_be    (be_q[1]),
    .b_addr  (addr_q[1]),
    .b_wdata (wdata_q[1]),
    .b_ack   (b_ack),
    .b_rdata (b_rdata)
  );

  initial begin
    clka = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clka = ~clka;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic string port_name(input int p);
    return (p == 0) ? "a" : "b";
  endfunction

  // Enabled bytes taken from new_w and the rest from old_w
  function automatic word_t apply_mask(input word_t old_w, input word_t new_w, input be_t mask);
    word_t bit_m;
    for (int c = 0; c < NB_COL; c++) begin
      bit_m[c*COL_WIDTH +: COL_WIDTH] = {COL_WIDTH{mask[c]}};
    end
    return (old_w & ~bit_m) | (new_w & bit_m);
  endfunction

  // Fold RAM accesses into the model half a cycle after the access edge
  always @(negedge clka) begin
    for (int p = 0; p < 2; p++) begin
      if (post_seq[p] != seen_seq[p]) begin
        exp_rdata[p] = apply_mask(shadow[post_addr[p]], post_wdata[p], post_mask[p]);
      end
    end
    for (int p = 1; p >= 0; p--) begin  // B first so A lands last on shared bytes
      if (post_seq[p] != seen_seq[p]) begin
        shadow[post_addr[p]] = apply_mask(shadow[post_addr[p]], post_wdata[p], post_mask[p]);
        seen_seq[p] = post_seq[p];
      end
    end
  end

  for (genvar p = 0; p < 2; p++) begin : g_check
    reset_state: assert property (@(posedge clka)
      $fell(rsta) |-> (!ack_w[p] && rdata_w[p] == '0))
      else begin
        $display("[FAIL] %s_ack %h %s_rdata %h after reset, expected 0 and 00000000",
                 port_name(p), ack_w[p], port_name(p), rdata_w[p]);
        fail_cnt++;
      end

    ack_needs_req: assert property (@(posedge clka) disable iff (rsta)
      !req_q[p] |=> !$rose(ack_w[p]))
      else begin
        $display("[FAIL] %s_ack rose to %h on an edge where %s_req was sampled 0",
                 port_name(p), ack_w[p], port_name(p));
        fail_cnt++;
      end

    ack_holds: assert property (@(posedge clka) disable iff (rsta)
      (ack_w[p] && req_q[p]) |=> ack_w[p])
      else begin
        $display("[FAIL] %s_ack dropped to %h while %s_req was still high",
                 port_name(p), ack_w[p], port_name(p));
        fail_cnt++;
      end

    ack_releases: assert property (@(posedge clka) disable iff (rsta)
      (ack_w[p] && !req_q[p]) |=> !ack_w[p])
      else begin
        $display("[FAIL] %s_ack still %h one cycle after %s_req fell",
                 port_name(p), ack_w[p], port_name(p));
        fail_cnt++;
      end

    ack_latency: assert property (@(posedge clka) disable iff (rsta)
      $rose(req_q[p]) |-> ##(LAT + 1) $rose(ack_w[p]))
      else begin
        $display("Port %s ack did not rise exactly %0d edges after req was sampled",
                 port_name(p), LAT);
        fail_cnt++;
      end

    rdata_match: assert property (@(posedge clka) disable iff (rsta)
      $rose(ack_w[p]) |-> rdata_w[p] == exp_rdata[p])
      else begin
        $display("[FAIL] %s_rdata got %h expected %h",
                 port_name(p), rdata_w[p], exp_rdata[p]);
        fail_cnt++;
      end
  end

  // One full four-phase handshake entered and left on a falling edge
  task automatic run_txn(input int p, input logic we, input be_t be, input addr_t addr,
                         input word_t wdata, input int idle_cyc, input int hold_cyc);
    int wait_cyc;
    repeat (idle_cyc) @(negedge clka);
    we_q[p]    = we;
    be_q[p]    = be;
    addr_q[p]  = addr;
    wdata_q[p] = wdata;
    req_q[p]   = 1'b1;
    @(posedge clka);  // Agent samples req
    @(posedge clka);  // RAM access edge
    post_mask[p]  = we ? be : '0;  // Reads leave the RAM untouched
    post_addr[p]  = addr;
    post_wdata[p] = wdata;
    post_seq[p]   = post_seq[p] + 1;
    wait_cyc = 0;
    @(negedge clka);
    while (!ack_w[p] && wait_cyc < ACK_WAIT_MAX) begin
      @(negedge clka);
      wait_cyc++;
    end
    if (!ack_w[p]) begin
      $display("Port %s gave no ack within %0d cycles", port_name(p), ACK_WAIT_MAX);
      fail_cnt++;
    end
    repeat (hold_cyc) @(negedge clka);  // Extra back-pressure
    req_q[p]   = 1'b0;
    addr_q[p]  = addr_t'($urandom);  // Idle bus garbage must not matter
    wdata_q[p] = $urandom;
    wait_cyc = 0;
    @(negedge clka);
    while (ack_w[p] && wait_cyc < ACK_WAIT_MAX) begin
      @(negedge clka);
      wait_cyc++;
    end
    if (ack_w[p]) begin
      $display("Port %s kept ack high after req was released", port_name(p));
      fail_cnt++;
    end
    txn_cnt++;
  endtask

  task automatic finish_test(input string name, input int txn_start, input int fail_start);
    repeat (4) @(negedge clka);  // Let trailing assertions sample
    test_cnt++;
    $display("Test %0d %s: %0d transactions, %0d errors", test_cnt, name,
             txn_cnt - txn_start, fail_cnt - fail_start);
  endtask

  task automatic check_handshake();
    int t0;
    int f0;
    t0 = txn_cnt;
    f0 = fail_cnt;
    run_txn(0, 1'b1, 4'hF, addr_t'(16), 32'hA5A5_0F0F, 0, 4);
    run_txn(1, 1'b0, 4'hF, addr_t'(16), 32'h0, 1, 6);
    fork
      run_txn(0, 1'b0, 4'h0, addr_t'(16), 32'h0, 0, 2);
      run_txn(1, 1'b1, 4'h5, addr_t'(17), 32'h1234_5678, 2, 5);
    join
    finish_test("handshake", t0, f0);
  endtask

  task automatic merge_writes();
    int t0;
    int f0;
    t0 = txn_cnt;
    f0 = fail_cnt;
    for (int i = 0; i < N_MERGE; i++) begin  // Small range so masks stack up
      run_txn(i % 2, 1'b1, be_t'($urandom_range(0, 15)), addr_t'($urandom_range(0, 3)),
              $urandom, 0, 0);
    end
    finish_test("write-first merge", t0, f0);
  endtask

  task automatic cross_port_reads();
    int    t0;
    int    f0;
    addr_t addr;
    t0 = txn_cnt;
    f0 = fail_cnt;
    for (int i = 0; i < N_PAIRS; i++) begin
      addr = addr_t'($urandom_range(0, 63));
      run_txn(0, 1'b1, be_t'($urandom_range(1, 15)), addr, $urandom, 0, 0);
      run_txn(1, 1'b0, 4'h0, addr, 32'h0, 0, 0);
      run_txn(1, 1'b1, be_t'($urandom_range(1, 15)), addr, $urandom, 0, 0);
      run_txn(0, 1'b0, 4'h0, addr, 32'h0, 0, 0);
    end
    for (int i = 0; i < N_RAND_RD; i++) begin
      run_txn(i % 2, 1'b0, 4'h0, addr_t'($urandom_range(0, 63)), 32'h0, 0, 0);
    end
    finish_test("cross-port read-back", t0, f0);
  endtask

  task automatic colliding_writes();
    int    t0;
    int    f0;
    int    col;
    addr_t addr;
    be_t   ma;
    be_t   mb;
    t0 = txn_cnt;
    f0 = fail_cnt;
    for (int i = 0; i < N_COLL; i++) begin
      addr = addr_t'($urandom_range(64, 127));
      run_txn(0, 1'b1, 4'hF, addr, $urandom, 0, 0);  // Known old bytes
      if (i == 0) begin
        ma = 4'b0011;  // Overlap col 1, B only col 2, old col 3
        mb = 4'b0110;
      end else if (i == 1) begin
        ma = 4'b1100;
        mb = 4'b0110;
      end else begin
        ma = be_t'($urandom_range(0, 15));
        mb = be_t'($urandom_range(0, 15));
        col = $urandom_range(0, NB_COL - 1);
        ma[col] = 1'b1;  // Force at least one shared byte
        mb[col] = 1'b1;
      end
      fork
        run_txn(0, 1'b1, ma, addr, $urandom, 0, 0);
        run_txn(1, 1'b1, mb, addr, $urandom, 0, 0);
      join
      run_txn(0, 1'b0, 4'h0, addr, 32'h0, 0, 0);
      run_txn(1, 1'b0, 4'h0, addr, 32'h0, 0, 0);
    end
    finish_test("collision", t0, f0);
  endtask

  task automatic mix_port(input int p);
    for (int i = 0; i < N_MIX / 2; i++) begin
      run_txn(p, 1'($urandom_range(0, 1)), be_t'($urandom_range(0, 15)),
              addr_t'($urandom_range(0, 15)), $urandom,
              $urandom_range(0, 3), $urandom_range(0, 3));
    end
  endtask

  task automatic random_mix();
    int t0;
    int f0;
    t0 = txn_cnt;
    f0 = fail_cnt;
    fork
      mix_port(0);
      mix_port(1);
    join
    finish_test("random mix", t0, f0);
  endtask

  initial begin
    int t0;
    int f0;
    void'($urandom(31));  // Single seed for the whole run
    rsta = 1'b1;
    for (int p = 0; p < 2; p++) begin
      req_q[p]   = 1'b0;
      we_q[p]    = 1'b0;
      be_q[p]    = '0;
      addr_q[p]  = '0;
      wdata_q[p] = '0;
    end
    t0 = txn_cnt;
    f0 = fail_cnt;
    repeat (3) @(posedge clka);
    @(negedge clka);
    rsta = 1'b0;
    finish_test("reset state", t0, f0);
    check_handshake();
    merge_writes();
    cross_port_reads();
    colliding_writes();
    random_mix();
    $display("Tests run: %0d, transactions: %0d, errors: %0d", test_cnt, txn_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_mem_subsys

// File: filelist.f
source/mem_pkg.sv
source/dpram_byte_write.sv
source/port_agent.sv
source/mem_subsys.sv
dv/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the scratchpad testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_mem_subsys \
  -f filelist.f \
  -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi
